//--- source/core_pkg.sv
package core_pkg;

	// Datapath word
	localparam int xlen = 32;

	// ALU function codes, 20 and up are invalid
	localparam logic [4:0] alu_add     = 5'd0;
	localparam logic [4:0] alu_sub     = 5'd1;
	localparam logic [4:0] alu_xor     = 5'd2;
	localparam logic [4:0] alu_or      = 5'd3;
	localparam logic [4:0] alu_and     = 5'd4;
	localparam logic [4:0] alu_sll     = 5'd5;
	localparam logic [4:0] alu_srl     = 5'd6;
	localparam logic [4:0] alu_sra     = 5'd7;
	localparam logic [4:0] alu_slt     = 5'd8;
	localparam logic [4:0] alu_sltu    = 5'd9;
	localparam logic [4:0] alu_mul     = 5'd10;
	localparam logic [4:0] alu_mulh    = 5'd11;
	localparam logic [4:0] alu_mulhsu  = 5'd12;
	localparam logic [4:0] alu_mulhu   = 5'd13;
	localparam logic [4:0] alu_div     = 5'd14;
	localparam logic [4:0] alu_divu    = 5'd15;
	localparam logic [4:0] alu_rem     = 5'd16;
	localparam logic [4:0] alu_remu    = 5'd17;
	localparam logic [4:0] alu_fcvtsw  = 5'd18;
	localparam logic [4:0] alu_fcvtswu = 5'd19;

	// Forwarding source, any other value reads the register file
	localparam logic [2:0] fwd_rf  = 3'd0;
	localparam logic [2:0] fwd_mem = 3'd1;
	localparam logic [2:0] fwd_wb  = 3'd2;

	// Operand selects
	localparam logic [1:0] sel_rs  = 2'd0;
	localparam logic [1:0] sel_pc  = 2'd1;
	localparam logic [1:0] sel_imm = 2'd1;

	// Branch conditions in br_ctrl[2:0]; br_ctrl[3] selects a JALR target
	localparam logic [2:0] br_beq  = 3'd0;
	localparam logic [2:0] br_bne  = 3'd1;
	localparam logic [2:0] br_unc  = 3'd2;
	localparam logic [2:0] br_none = 3'd3;
	localparam logic [2:0] br_blt  = 3'd4;
	localparam logic [2:0] br_bge  = 3'd5;
	localparam logic [2:0] br_bltu = 3'd6;
	localparam logic [2:0] br_bgeu = 3'd7;

	// Rounding modes, unlisted values act as RNE
	localparam logic [2:0] rm_rne = 3'd0;
	localparam logic [2:0] rm_rtz = 3'd1;
	localparam logic [2:0] rm_rdn = 3'd2;
	localparam logic [2:0] rm_rup = 3'd3;
	localparam logic [2:0] rm_rmm = 3'd4;

	// Single precision exponent bias
	localparam logic [7:0] f32_bias = 8'd127;

	// Divider iterations and step counter width
	localparam int div_steps = 32;
	localparam int div_cnt_w = $clog2(div_steps);

endpackage

//--- source/operand_select.sv
`timescale 1ns/1ps

module operand_select import core_pkg::*; (
	input  logic [9:0]      mux_sel,
	input  logic [xlen-1:0] rf_rs1_data,
	input  logic [xlen-1:0] rf_rs2_data,
	input  logic [xlen-1:0] pc,
	input  logic [xlen-1:0] imm,
	input  logic [xlen-1:0] mem_data,
	input  logic [xlen-1:0] wb_data,
	output logic [xlen-1:0] rs1_data,
	output logic [xlen-1:0] rs2_data,
	output logic [xlen-1:0] opa,
	output logic [xlen-1:0] opb
);

	// MEM result is newer than WB, decode picks which one applies
	function automatic logic [xlen-1:0] forward(input logic [2:0] sel,
			input logic [xlen-1:0] rf_data);
		case (sel)
			fwd_mem: forward = mem_data;
			fwd_wb:  forward = wb_data;
			default: forward = rf_data;
		endcase
	endfunction

	assign rs1_data = forward(mux_sel[5:3], rf_rs1_data);
	assign rs2_data = forward(mux_sel[2:0], rf_rs2_data);

	always_comb begin
		case (mux_sel[9:8])
			sel_rs:  opa = rs1_data;
			sel_pc:  opa = pc;
			default: opa = '0;
		endcase
	end

	// Constant four serves JAL/JALR link values
	always_comb begin
		case (mux_sel[7:6])
			sel_rs:  opb = rs2_data;
			sel_imm: opb = imm;
			default: opb = xlen'(4);
		endcase
	end

endmodule

//--- source/divider.sv
`timescale 1ns/1ps

module divider import core_pkg::*; (
	input  logic            clk,
	input  logic            rst,
	input  logic            vld,
	input  logic [4:0]      alu_func,
	input  logic [xlen-1:0] opa,
	input  logic [xlen-1:0] opb,
	output logic [xlen-1:0] quotient,
	output logic [xlen-1:0] remainder,
	output logic            busy
);

	logic                 is_div;
	logic                 is_signed;
	logic                 start;
	logic                 running;
	logic                 done;
	logic                 last;
	logic [div_cnt_w-1:0] step;
	logic [xlen-1:0]      dividend;
	logic [xlen-1:0]      divisor;
	logic [xlen-1:0]      quo;
	logic [xlen-1:0]      rem;
	logic                 neg_quo;
	logic                 neg_rem;
	logic [xlen:0]        shifted;
	logic [xlen+1:0]      trial;

	assign is_div    = alu_func inside {alu_div, alu_divu, alu_rem, alu_remu};
	assign is_signed = (alu_func == alu_div) || (alu_func == alu_rem);
	assign start     = vld && is_div && !done && !running;
	assign busy      = start || running;
	assign last      = (step == div_cnt_w'(div_steps - 1));

	// One restoring step, top bit of trial is the borrow
	assign shifted = {rem, quo[xlen-1]};
	assign trial   = {1'b0, shifted} - {2'b00, divisor};

	always_ff @(posedge clk) begin
		if (rst) begin
			running <= 1'b0;
			done    <= 1'b0;
			step    <= '0;
		end else begin
			if (start) begin
				running <= 1'b1;
				step    <= '0;
			end else if (running) begin
				step <= step + 1'b1;
				if (last)
					running <= 1'b0;
			end
			// Result held for one cycle only, the consuming edge clears it
			done <= running && last;
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			dividend <= opa;
			divisor  <= (is_signed && opb[xlen-1]) ? -opb : opb;
			quo      <= (is_signed && opa[xlen-1]) ? -opa : opa;
			rem      <= '0;
			neg_quo  <= is_signed && (opa[xlen-1] ^ opb[xlen-1]);
			neg_rem  <= is_signed && opa[xlen-1];
		end else if (running) begin
			if (trial[xlen+1]) begin
				rem <= shifted[xlen-1:0];
				quo <= {quo[xlen-2:0], 1'b0};
			end else begin
				rem <= trial[xlen-1:0];
				quo <= {quo[xlen-2:0], 1'b1};
			end
		end
	end

	// Overflow comes out of the magnitude path as 0x80000000 rem 0
	always_comb begin
		if (divisor == '0) begin
			quotient  = '1;
			remainder = dividend;
		end else begin
			quotient  = neg_quo ? -quo : quo;
			remainder = neg_rem ? -rem : rem;
		end
	end

endmodule

//--- source/int_to_float.sv
`timescale 1ns/1ps

module int_to_float import core_pkg::*; (
	input  logic            clk,
	input  logic            rst,
	input  logic            vld,
	input  logic [4:0]      alu_func,
	input  logic [xlen-1:0] opa,
	input  logic [2:0]      rm,
	output logic [xlen-1:0] fpu_res,
	output logic            busy
);

	logic            is_cvt;
	logic            start;
	logic            done;
	logic            sign;
	logic [xlen-1:0] mag;
	logic [xlen-1:0] norm;
	logic [4:0]      msb;
	logic            guard;
	logic            sticky;
	logic            inc;
	logic [24:0]     sum;
	logic [7:0]      exp;
	logic [22:0]     frac;
	logic [xlen-1:0] result;

	assign is_cvt = (alu_func == alu_fcvtsw) || (alu_func == alu_fcvtswu);
	assign start  = vld && is_cvt && !done;
	assign busy   = start;

	assign sign = (alu_func == alu_fcvtsw) && opa[xlen-1];
	assign mag  = sign ? -opa : opa;

	// Leading one position
	always_comb begin
		msb = '0;
		for (int i = 0; i < xlen; i++) begin
			if (mag[i])
				msb = 5'(i);
		end
	end

	// Hidden bit lands in bit 31
	assign norm   = mag << (5'd31 - msb);
	assign guard  = norm[7];
	assign sticky = |norm[6:0];

	always_comb begin
		case (rm)
			rm_rtz:  inc = 1'b0;
			rm_rdn:  inc = sign && (guard || sticky);
			rm_rup:  inc = !sign && (guard || sticky);
			rm_rmm:  inc = guard;
			rm_rne:  inc = guard && (sticky || norm[8]);
			default: inc = guard && (sticky || norm[8]);
		endcase
	end

	// Carry out of the significand bumps the exponent
	assign sum  = {1'b0, norm[31:8]} + {24'd0, inc};
	assign frac = sum[24] ? sum[23:1] : sum[22:0];
	assign exp  = f32_bias + {3'b000, msb} + {7'd0, sum[24]};

	assign result = (mag == '0) ? '0 : {sign, exp, frac};

	always_ff @(posedge clk) begin
		if (rst)
			done <= 1'b0;
		else
			done <= start;
	end

	always_ff @(posedge clk) begin
		if (start)
			fpu_res <= result;
	end

endmodule

//--- source/ex_stage.sv
`timescale 1ns/1ps

module ex_stage import core_pkg::*; (
	input  logic            clk,
	input  logic            rst,
	input  logic [xlen-1:0] rf_rs1_data,
	input  logic [xlen-1:0] rf_rs2_data,
	input  logic [xlen-1:0] id_ex_pc,
	input  logic [xlen-1:0] id_ex_imm,
	input  logic [9:0]      id_ex_mux_sel,
	input  logic [3:0]      id_ex_br_ctrl,
	input  logic [4:0]      id_ex_alu_func,
	input  logic            id_ex_vld,
	input  logic [xlen-1:0] mem_data,
	input  logic [xlen-1:0] wb_data,
	output logic [xlen-1:0] ex_mem_din,
	output logic [xlen-1:0] ex_alu_res,
	output logic            ex_vld,
	output logic [xlen-1:0] ex_br_pc,
	output logic            ex_take_br,
	output logic            ex_alu_busy
);

	logic [xlen-1:0]    rs1_data;
	logic [xlen-1:0]    rs2_data;
	logic [xlen-1:0]    opa;
	logic [xlen-1:0]    opb;
	logic [xlen-1:0]    quotient;
	logic [xlen-1:0]    remainder;
	logic [xlen-1:0]    fpu_res;
	logic               div_busy;
	logic               fpu_busy;
	logic               sign_opa;
	logic               sign_opb;
	logic signed [xlen:0]     mult_opa;
	logic signed [xlen:0]     mult_opb;
	logic signed [2*xlen+1:0] mult_res;
	logic               br_cond;
	logic [xlen-1:0]    jalr_sum;

	operand_select i_operand_select (
		.mux_sel     (id_ex_mux_sel),
		.rf_rs1_data (rf_rs1_data),
		.rf_rs2_data (rf_rs2_data),
		.pc          (id_ex_pc),
		.imm         (id_ex_imm),
		.mem_data    (mem_data),
		.wb_data     (wb_data),
		.rs1_data    (rs1_data),
		.rs2_data    (rs2_data),
		.opa         (opa),
		.opb         (opb)
	);

	divider i_divider (
		.clk       (clk),
		.rst       (rst),
		.vld       (id_ex_vld),
		.alu_func  (id_ex_alu_func),
		.opa       (opa),
		.opb       (opb),
		.quotient  (quotient),
		.remainder (remainder),
		.busy      (div_busy)
	);

	int_to_float i_int_to_float (
		.clk      (clk),
		.rst      (rst),
		.vld      (id_ex_vld),
		.alu_func (id_ex_alu_func),
		.opa      (opa),
		.rm       (id_ex_imm[2:0]),
		.fpu_res  (fpu_res),
		.busy     (fpu_busy)
	);

	assign ex_alu_busy = div_busy || fpu_busy;
	assign ex_mem_din  = rs2_data;

	// Extension bit replaces the sign for unsigned operands
	assign sign_opb = (id_ex_alu_func == alu_mulh);
	assign sign_opa = sign_opb || (id_ex_alu_func == alu_mulhsu);
	assign mult_opa = {sign_opa && opa[xlen-1], opa};
	assign mult_opb = {sign_opb && opb[xlen-1], opb};
	assign mult_res = mult_opa * mult_opb;

	always_comb begin
		ex_alu_res = '0;
		ex_vld     = id_ex_vld;
		case (id_ex_alu_func)
			alu_add:     ex_alu_res = opa + opb;
			alu_sub:     ex_alu_res = opa - opb;
			alu_xor:     ex_alu_res = opa ^ opb;
			alu_or:      ex_alu_res = opa | opb;
			alu_and:     ex_alu_res = opa & opb;
			alu_sll:     ex_alu_res = opa << opb[4:0];
			alu_srl:     ex_alu_res = opa >> opb[4:0];
			alu_sra:     ex_alu_res = $signed(opa) >>> opb[4:0];
			alu_slt:     ex_alu_res = {31'd0, $signed(opa) < $signed(opb)};
			alu_sltu:    ex_alu_res = {31'd0, opa < opb};
			alu_mul:     ex_alu_res = mult_res[xlen-1:0];
			alu_mulh, alu_mulhsu, alu_mulhu:
				ex_alu_res = mult_res[2*xlen-1:xlen];
			alu_div, alu_divu:       ex_alu_res = quotient;
			alu_rem, alu_remu:       ex_alu_res = remainder;
			alu_fcvtsw, alu_fcvtswu: ex_alu_res = fpu_res;
			default:     ex_vld = 1'b0;
		endcase
	end

	// Equality tests SUB result, compares test SLT/SLTU bit 0
	always_comb begin
		case (id_ex_br_ctrl[2:0])
			br_beq:  br_cond = (ex_alu_res == '0);
			br_bne:  br_cond = (ex_alu_res != '0);
			br_blt:  br_cond = ex_alu_res[0];
			br_bge:  br_cond = !ex_alu_res[0];
			br_bltu: br_cond = ex_alu_res[0];
			br_bgeu: br_cond = !ex_alu_res[0];
			br_unc:  br_cond = 1'b1;
			default: br_cond = 1'b0;
		endcase
	end

	assign ex_take_br = ex_vld && br_cond;

	assign jalr_sum = rs1_data + id_ex_imm;
	assign ex_br_pc = id_ex_br_ctrl[3] ? {jalr_sum[xlen-1:1], 1'b0} : id_ex_pc + id_ex_imm;

endmodule

//--- test/ex_model.svh
`ifndef EX_MODEL_SVH
`define EX_MODEL_SVH

function automatic logic [31:0] forward_value(input logic [2:0] sel, input logic [31:0] rf,
		input logic [31:0] mem, input logic [31:0] wb);
	if (sel == fwd_mem)
		return mem;
	if (sel == fwd_wb)
		return wb;
	return rf;
endfunction

function automatic logic [31:0] select_opa(input logic [1:0] sel, input logic [31:0] rs1,
		input logic [31:0] pc);
	if (sel == sel_rs)
		return rs1;
	return (sel == sel_pc) ? pc : 32'd0;
endfunction

function automatic logic [31:0] select_opb(input logic [1:0] sel, input logic [31:0] rs2,
		input logic [31:0] imm);
	if (sel == sel_rs)
		return rs2;
	return (sel == sel_imm) ? imm : 32'd4;
endfunction

// Integer, multiply and divide results per the RISC-V rules
function automatic logic [31:0] alu_expect(input logic [4:0] func, input logic [31:0] a,
		input logic [31:0] b);
	logic [63:0]        p_ss;
	logic [63:0]        p_su;
	logic [63:0]        p_uu;
	logic               ovf;
	logic signed [31:0] quo_s;
	logic signed [31:0] rem_s;
	p_ss = {{32{a[31]}}, a} * {{32{b[31]}}, b};
	p_su = {{32{a[31]}}, a} * {32'd0, b};
	p_uu = {32'd0, a} * {32'd0, b};
	ovf  = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
	// Signed quotient and remainder, truncated toward zero
	quo_s = 32'sd0;
	rem_s = 32'sd0;
	if ((b != 0) && !ovf) begin
		quo_s = $signed(a) / $signed(b);
		rem_s = $signed(a) % $signed(b);
	end
	case (func)
		alu_add:    return a + b;
		alu_sub:    return a - b;
		alu_xor:    return a ^ b;
		alu_or:     return a | b;
		alu_and:    return a & b;
		alu_sll:    return a << b[4:0];
		alu_srl:    return a >> b[4:0];
		alu_sra:    return $signed(a) >>> b[4:0];
		alu_slt:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
		alu_sltu:   return (a < b) ? 32'd1 : 32'd0;
		alu_mul:    return p_ss[31:0];
		alu_mulh:   return p_ss[63:32];
		alu_mulhsu: return p_su[63:32];
		alu_mulhu:  return p_uu[63:32];
		alu_div:    return (b == 0) ? 32'hffff_ffff : (ovf ? a : quo_s);
		alu_divu:   return (b == 0) ? 32'hffff_ffff : a / b;
		alu_rem:    return (b == 0) ? a : (ovf ? 32'd0 : rem_s);
		alu_remu:   return (b == 0) ? a : a % b;
		default:    return 32'd0;
	endcase
endfunction

function automatic logic [31:0] cvt_expect(input logic is_signed, input logic [31:0] a,
		input logic [2:0] rm);
	logic        neg;
	logic        up;
	logic [31:0] mag;
	logic [31:0] sig;
	logic [31:0] rest;
	logic [31:0] half;
	int          e;
	int          sh;
	neg = is_signed && a[31];
	mag = neg ? -a : a;
	if (mag == 0)
		return 32'd0;
	e = 31;
	while (!mag[e])
		e--;
	sh   = (e > 23) ? e - 23 : 0;
	sig  = (e > 23) ? mag >> sh : mag << (23 - e);
	rest = mag & ((32'd1 << sh) - 32'd1);
	half = (sh > 0) ? 32'd1 << (sh - 1) : 32'd0;
	case (rm)
		rm_rtz:  up = 1'b0;
		rm_rdn:  up = neg && (rest != 0);
		rm_rup:  up = !neg && (rest != 0);
		rm_rmm:  up = (rest != 0) && (rest >= half);
		default: up = (rest > half) || ((rest != 0) && (rest == half) && sig[0]);
	endcase
	sig = sig + 32'(up);
	if (sig[24]) begin
		sig = sig >> 1;
		e++;
	end
	return {neg, 8'(127 + e), sig[22:0]};
endfunction

// ALU op that decode pairs with each branch code
function automatic logic [4:0] branch_func(input logic [2:0] code);
	case (code)
		br_beq, br_bne:   return alu_sub;
		br_blt, br_bge:   return alu_slt;
		br_bltu, br_bgeu: return alu_sltu;
		default:          return alu_add;
	endcase
endfunction

function automatic logic branch_expect(input logic [2:0] code, input logic [31:0] a,
		input logic [31:0] b);
	case (code)
		br_beq:  return a == b;
		br_bne:  return a != b;
		br_blt:  return $signed(a) < $signed(b);
		br_bge:  return $signed(a) >= $signed(b);
		br_bltu: return a < b;
		br_bgeu: return a >= b;
		br_unc:  return 1'b1;
		default: return 1'b0;
	endcase
endfunction

function automatic logic [31:0] target_expect(input logic jalr, input logic [31:0] pc,
		input logic [31:0] rs1, input logic [31:0] imm);
	if (jalr)
		return (rs1 + imm) & ~32'd1;
	return pc + imm;
endfunction

`endif

//--- test/ex_stage_tb.sv
`timescale 1ns/1ps

module ex_stage_tb import core_pkg::*; ();

	localparam int n_alu      = 150;
	localparam int n_mul_rand = 20;
	localparam int n_div_rand = 15;
	localparam int n_cvt_rand = 8;
	localparam int n_idle     = 10;
	localparam int num_tests  = n_alu + 4 * (n_mul_rand + 16) + 4 * (n_div_rand + 4)
		+ 10 * (n_cvt_rand + 6) + 48 + 12 + n_idle + 1;
	// A divide is the longest op at 35 cycles
	localparam int cycle_limit = num_tests * 40 + 100;

	logic            clk = 1'b0;
	logic            rst;
	logic [31:0]     rf_rs1_data;
	logic [31:0]     rf_rs2_data;
	logic [31:0]     id_ex_pc;
	logic [31:0]     id_ex_imm;
	logic [9:0]      id_ex_mux_sel;
	logic [3:0]      id_ex_br_ctrl;
	logic [4:0]      id_ex_alu_func;
	logic            id_ex_vld;
	logic [31:0]     mem_data;
	logic [31:0]     wb_data;
	logic [31:0]     ex_mem_din;
	logic [31:0]     ex_alu_res;
	logic            ex_vld;
	logic [31:0]     ex_br_pc;
	logic            ex_take_br;
	logic            ex_alu_busy;
	int              seed = 32'hb782;
	int              cycles = 0;
	logic [31:0]     corner [4] = '{32'h8000_0000, 32'hffff_ffff, 32'h0, 32'h7fff_ffff};
	logic [31:0]     cvt_vals [6] = '{32'h0100_0001, 32'h0100_0003, 32'hffff_ffff,
		32'h7fff_ffc0, 32'h8000_0000, 32'h0};
	// Equal, signed less / unsigned greater, and the reverse
	logic [31:0]     pair_a [3] = '{32'hffff_fff0, 32'hffff_fff0, 32'h0000_0010};
	logic [31:0]     pair_b [3] = '{32'hffff_fff0, 32'h0000_0010, 32'hffff_fff0};

	`include "ex_model.svh"

	ex_stage i_dut (
		.clk            (clk),
		.rst            (rst),
		.rf_rs1_data    (rf_rs1_data),
		.rf_rs2_data    (rf_rs2_data),
		.id_ex_pc       (id_ex_pc),
		.id_ex_imm      (id_ex_imm),
		.id_ex_mux_sel  (id_ex_mux_sel),
		.id_ex_br_ctrl  (id_ex_br_ctrl),
		.id_ex_alu_func (id_ex_alu_func),
		.id_ex_vld      (id_ex_vld),
		.mem_data       (mem_data),
		.wb_data        (wb_data),
		.ex_mem_din     (ex_mem_din),
		.ex_alu_res     (ex_alu_res),
		.ex_vld         (ex_vld),
		.ex_br_pc       (ex_br_pc),
		.ex_take_br     (ex_take_br),
		.ex_alu_busy    (ex_alu_busy)
	);

	always #10 clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit) begin
			$display("Timeout: run did not finish within %0d cycles", cycle_limit);
			$display("Simulation failed");
			$fatal(1);
		end
	end

	function automatic logic [31:0] next_random();
		return $random(seed);
	endfunction

	// Random forwarding, operands from rs1 and rs2
	function automatic logic [9:0] rand_fwd();
		logic [31:0] r;
		r = next_random();
		return {4'b0000, r[5:0]};
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		assert (actual === expected) else begin
			$display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
			$display("Simulation failed");
			$fatal(1);
		end
	endtask

	// Drive one instruction, hold it through the stall, then check
	task automatic run_op(input string name, input logic [4:0] func, input logic [3:0] br,
			input logic [9:0] mux, input logic [31:0] rs1, input logic [31:0] rs2,
			input logic [31:0] imm, input logic vld);
		logic [31:0] fwd1;
		logic [31:0] fwd2;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] res;
		logic        valid;
		logic        take;
		int          busy;
		int          busy_exp;
		@(posedge clk);
		rf_rs1_data    <= rs1;
		rf_rs2_data    <= rs2;
		id_ex_pc       <= next_random() & ~32'd3;
		id_ex_imm      <= imm;
		id_ex_mux_sel  <= mux;
		id_ex_br_ctrl  <= br;
		id_ex_alu_func <= func;
		id_ex_vld      <= vld;
		mem_data       <= next_random();
		wb_data        <= next_random();
		@(negedge clk);
		busy = 0;
		while (ex_alu_busy) begin
			busy++;
			@(negedge clk);
		end
		fwd1  = forward_value(mux[5:3], rs1, mem_data, wb_data);
		fwd2  = forward_value(mux[2:0], rs2, mem_data, wb_data);
		a     = select_opa(mux[9:8], fwd1, id_ex_pc);
		b     = select_opb(mux[7:6], fwd2, imm);
		valid = vld && (func <= alu_fcvtswu);
		take  = valid && branch_expect(br[2:0], a, b);
		if (vld && (func inside {alu_div, alu_divu, alu_rem, alu_remu}))
			busy_exp = div_steps + 1;
		else if (vld && (func inside {alu_fcvtsw, alu_fcvtswu}))
			busy_exp = 1;
		else
			busy_exp = 0;
		check_value({name, " busy cycles"}, 32'(busy_exp), 32'(busy));
		check_value({name, " ex_vld"}, 32'(valid), 32'(ex_vld));
		check_value({name, " ex_mem_din"}, fwd2, ex_mem_din);
		check_value({name, " ex_take_br"}, 32'(take), 32'(ex_take_br));
		check_value({name, " ex_br_pc"}, target_expect(br[3], id_ex_pc, fwd1, imm), ex_br_pc);
		if (valid) begin
			if (func inside {alu_fcvtsw, alu_fcvtswu})
				res = cvt_expect(func == alu_fcvtsw, a, imm[2:0]);
			else
				res = alu_expect(func, a, b);
			check_value({name, " ex_alu_res"}, res, ex_alu_res);
		end
	endtask

	initial begin
		logic [31:0] v;
		logic [31:0] w;
		logic [31:0] r;
		rst            = 1'b1;
		rf_rs1_data    = '0;
		rf_rs2_data    = '0;
		id_ex_pc       = '0;
		id_ex_imm      = '0;
		id_ex_mux_sel  = '0;
		id_ex_br_ctrl  = {1'b0, br_none};
		id_ex_alu_func = alu_add;
		id_ex_vld      = 1'b0;
		mem_data       = '0;
		wb_data        = '0;
		repeat (3) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		check_value("reset busy", 32'd0, 32'(ex_alu_busy));

		for (int i = 0; i < n_alu; i++) begin
			r = next_random();
			run_op("alu", 5'(next_random() % 10), {r[0], br_none}, 10'(next_random()),
				next_random(), next_random(), next_random(), 1'b1);
		end

		for (int f = alu_mul; f <= alu_mulhu; f++) begin
			for (int i = 0; i < n_mul_rand; i++)
				run_op("mul", 5'(f), {1'b0, br_none}, rand_fwd(), next_random(),
					next_random(), next_random(), 1'b1);
			for (int i = 0; i < 4; i++)
				for (int j = 0; j < 4; j++)
					run_op("mul corner", 5'(f), {1'b0, br_none}, 10'd0, corner[i],
						corner[j], next_random(), 1'b1);
		end

		for (int f = alu_div; f <= alu_remu; f++) begin
			for (int i = 0; i < n_div_rand; i++) begin
				v = next_random();
				w = next_random();
				if (i % 2 == 1)
					w = w & 32'h0000_00ff;
				run_op("div", 5'(f), {1'b0, br_none}, rand_fwd(), v, w, next_random(), 1'b1);
			end
			run_op("div by zero", 5'(f), {1'b0, br_none}, 10'd0, next_random(), 32'd0,
				32'd0, 1'b1);
			run_op("div overflow", 5'(f), {1'b0, br_none}, 10'd0, 32'h8000_0000,
				32'hffff_ffff, 32'd0, 1'b1);
			v = next_random();
			w = next_random();
			run_op("div repeat", 5'(f), {1'b0, br_none}, 10'd0, v, w, 32'd0, 1'b1);
			run_op("div repeat", 5'(f), {1'b0, br_none}, 10'd0, v, w, 32'd0, 1'b1);
		end

		// Rounding mode rides in imm[2:0]
		for (int f = alu_fcvtsw; f <= alu_fcvtswu; f++) begin
			for (int m = 0; m < 5; m++) begin
				for (int i = 0; i < n_cvt_rand; i++)
					run_op("fcvt", 5'(f), {1'b0, br_none}, rand_fwd(), next_random(),
						next_random(), {29'(next_random()), 3'(m)}, 1'b1);
				for (int i = 0; i < 6; i++)
					run_op("fcvt round", 5'(f), {1'b0, br_none}, 10'd0, cvt_vals[i],
						32'd0, {29'd0, 3'(m)}, 1'b1);
			end
		end

		for (int c = 0; c < 8; c++)
			for (int t = 0; t < 2; t++)
				for (int p = 0; p < 3; p++)
					run_op("branch", branch_func(3'(c)), {1'(t), 3'(c)}, 10'd0, pair_a[p],
						pair_b[p], next_random(), 1'b1);

		for (int f = 20; f < 32; f++)
			run_op("invalid func", 5'(f), {1'b0, br_unc}, 10'(next_random()),
				next_random(), next_random(), next_random(), 1'b1);
		for (int i = 0; i < n_idle; i++)
			run_op("vld low", 5'(next_random() % 20), {1'b0, br_unc}, 10'(next_random()),
				next_random(), next_random(), next_random(), 1'b0);

		$display("Simulation completed successfully");
		$finish;
	end

endmodule

//--- list.f
+incdir+test
source/core_pkg.sv
source/operand_select.sv
source/divider.sv
source/int_to_float.sv
source/ex_stage.sv
test/ex_stage_tb.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -Wno-fatal
TOP       ?= ex_stage_tb
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
